// File: verilog/uart_cmd_pkg.sv
package uart_cmd_pkg;

    // Decoded command opcodes. Unknown opcode bytes map to OP_BAD
    typedef enum logic [2:0] {
        OP_LOAD,
        OP_ADD,
        OP_XOR,
        OP_READ,
        OP_BAD
    } opcode_e;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    // Queue depth in the execute block, also the decoder's starting credit
    localparam int CMD_CREDITS = 2;

    // Wide enough to hold 0..CMD_CREDITS
    localparam int CREDIT_W = $clog2(CMD_CREDITS + 1);

    // Queue pointer width
    localparam int PTR_W = $clog2(CMD_CREDITS);

    // Response to an unknown opcode
    localparam logic [7:0] ERR_CODE = 8'hEE;

    // Opcode byte values on the wire
    localparam logic [7:0] OPB_LOAD = 8'h80;
    localparam logic [7:0] OPB_ADD  = 8'h81;
    localparam logic [7:0] OPB_XOR  = 8'h82;
    localparam logic [7:0] OPB_READ = 8'h83;

endpackage

// File: verilog/cmd_if.sv
`timescale 1ns/1ps

interface cmd_if;
    import uart_cmd_pkg::*;

    // Command from decoder to execute queue
    logic       cmd_valid;
    opcode_e    cmd_op;
    logic [7:0] cmd_operand;

    // One pulse per freed queue entry
    logic       credit_ret;

    modport issuer (
        output cmd_valid,
        output cmd_op,
        output cmd_operand,
        input  credit_ret
    );

    modport queue (
        input  cmd_valid,
        input  cmd_op,
        input  cmd_operand,
        output credit_ret
    );

endinterface

// File: verilog/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic [15:0] baud_div_i,
    input  logic        rx_i,
    output logic [7:0]  rx_data_o,
    output logic        rx_valid_o
);
    import uart_cmd_pkg::*;

    rx_state_e   state;
    logic [15:0] cnt;
    logic [2:0]  bit_idx;
    logic        rx_prev;
    logic [15:0] half_div;
    logic        half_end;
    logic        bit_end;

    assign half_div = {1'b0, baud_div_i[15:1]};
    assign half_end = (cnt == half_div - 16'd1);
    assign bit_end  = (cnt == baud_div_i - 16'd1);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state      <= RX_IDLE;
            cnt        <= 16'd0;
            bit_idx    <= 3'd0;
            rx_prev    <= 1'b1;
            rx_valid_o <= 1'b0;
        end else begin
            rx_prev    <= rx_i;
            rx_valid_o <= 1'b0;
            case (state)
                RX_IDLE: begin
                    // Only a real falling edge starts a frame
                    if (rx_prev && !rx_i) begin
                        state <= RX_START;
                        cnt   <= 16'd0;
                    end
                end
                RX_START: begin
                    if (half_end) begin
                        cnt     <= 16'd0;
                        bit_idx <= 3'd0;
                        // Glitch on the line, back to idle
                        state   <= rx_i ? RX_IDLE : RX_DATA;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        cnt     <= 16'd0;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        cnt        <= 16'd0;
                        // Framing error drops the byte
                        rx_valid_o <= rx_i;
                        state      <= RX_IDLE;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Data bits land LSB first
    always_ff @(posedge clk_i) begin
        if (state == RX_DATA && bit_end) begin
            rx_data_o[bit_idx] <= rx_i;
        end
    end

endmodule

// File: verilog/cmd_decoder.sv
`timescale 1ns/1ps

module cmd_decoder (
    input  logic       clk_i,
    input  logic       rstn_i,
    input  logic [7:0] rx_data_i,
    input  logic       rx_valid_i,
    cmd_if.issuer      cmd
);
    import uart_cmd_pkg::*;

    logic                op_pending;
    opcode_e             op_q;
    opcode_e             op_dec;
    logic [CREDIT_W-1:0] credit_cnt;
    logic                issue;

    always_comb begin
        case (rx_data_i)
            OPB_LOAD: op_dec = OP_LOAD;
            OPB_ADD:  op_dec = OP_ADD;
            OPB_XOR:  op_dec = OP_XOR;
            OPB_READ: op_dec = OP_READ;
            default:  op_dec = OP_BAD;
        endcase
    end

    // Operand byte completes the command; without a credit it is dropped
    assign issue = rx_valid_i && op_pending && (credit_cnt != '0);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            op_pending    <= 1'b0;
            cmd.cmd_valid <= 1'b0;
            credit_cnt    <= CREDIT_W'(CMD_CREDITS);
        end else begin
            cmd.cmd_valid <= issue;

            if (rx_valid_i) begin
                if (!op_pending) begin
                    // Data bytes are ignored while waiting for an opcode
                    if (rx_data_i[7]) begin
                        op_pending <= 1'b1;
                    end
                end else begin
                    op_pending <= 1'b0;
                end
            end

            case ({issue, cmd.credit_ret})
                2'b10:   credit_cnt <= credit_cnt - CREDIT_W'(1);
                2'b01:   credit_cnt <= credit_cnt + CREDIT_W'(1);
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (rx_valid_i && !op_pending && rx_data_i[7]) begin
            op_q <= op_dec;
        end
        if (issue) begin
            cmd.cmd_op      <= op_q;
            cmd.cmd_operand <= rx_data_i;
        end
    end

endmodule

// File: verilog/acc_execute.sv
`timescale 1ns/1ps

module acc_execute (
    input  logic       clk_i,
    input  logic       rstn_i,
    cmd_if.queue       cmd,
    input  logic       tx_busy_i,
    output logic [7:0] res_data_o,
    output logic       res_valid_o
);
    import uart_cmd_pkg::*;

    opcode_e             q_op      [CMD_CREDITS];
    logic [7:0]          q_operand [CMD_CREDITS];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CREDIT_W-1:0] q_count;
    logic                q_empty;
    logic                push;
    logic                pop;
    logic [7:0]          acc;
    logic [7:0]          acc_next;

    assign q_empty = (q_count == '0);
    assign push    = cmd.cmd_valid;
    assign pop     = !q_empty && !tx_busy_i;

    always_comb begin
        acc_next = acc;
        case (q_op[rd_ptr])
            OP_LOAD: acc_next = q_operand[rd_ptr];
            OP_ADD:  acc_next = acc + q_operand[rd_ptr];
            OP_XOR:  acc_next = acc ^ q_operand[rd_ptr];
            default: acc_next = acc;
        endcase
    end

    // Execute cycle: response and freed credit go out together
    assign res_data_o     = (q_op[rd_ptr] == OP_BAD) ? ERR_CODE : acc_next;
    assign res_valid_o    = pop;
    assign cmd.credit_ret = pop;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q_count <= '0;
            acc     <= 8'd0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
                acc    <= acc_next;
            end
            if (push && !pop) begin
                q_count <= q_count + CREDIT_W'(1);
            end else if (pop && !push) begin
                q_count <= q_count - CREDIT_W'(1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            q_op[wr_ptr]      <= cmd.cmd_op;
            q_operand[wr_ptr] <= cmd.cmd_operand;
        end
    end

endmodule

// File: verilog/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic [15:0] baud_div_i,
    input  logic [7:0]  res_data_i,
    input  logic        res_valid_i,
    output logic        tx_o,
    output logic        tx_busy_o
);
    import uart_cmd_pkg::*;

    tx_state_e   state;
    logic [15:0] cnt;
    logic [2:0]  bit_idx;
    logic [7:0]  shreg;
    logic        bit_end;

    assign bit_end = (cnt == baud_div_i - 16'd1);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state     <= TX_IDLE;
            cnt       <= 16'd0;
            bit_idx   <= 3'd0;
            tx_o      <= 1'b1;
            tx_busy_o <= 1'b0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (res_valid_i) begin
                        state     <= TX_START;
                        cnt       <= 16'd0;
                        tx_o      <= 1'b0;
                        tx_busy_o <= 1'b1;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        cnt     <= 16'd0;
                        bit_idx <= 3'd0;
                        tx_o    <= shreg[0];
                        state   <= TX_DATA;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        cnt     <= 16'd0;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            tx_o  <= 1'b1;
                            state <= TX_STOP;
                        end else begin
                            tx_o <= shreg[0];
                        end
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                TX_STOP: begin
                    if (bit_end) begin
                        cnt       <= 16'd0;
                        tx_busy_o <= 1'b0;
                        state     <= TX_IDLE;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Shift out LSB first, next bit always sits at shreg[0]
    always_ff @(posedge clk_i) begin
        if (state == TX_IDLE && res_valid_i) begin
            shreg <= res_data_i;
        end else if ((state == TX_START || state == TX_DATA) && bit_end) begin
            shreg <= {1'b0, shreg[7:1]};
        end
    end

endmodule

// File: verilog/uart_cmd_top.sv
`timescale 1ns/1ps

module uart_cmd_top (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic [15:0] baud_div_i,
    input  logic        rx_i,
    output logic        tx_o,
    output logic        tx_busy_o
);

    logic [7:0] rx_data;
    logic       rx_valid;
    logic [7:0] res_data;
    logic       res_valid;

    cmd_if cmd_bus ();

    uart_rx u_rx (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .baud_div_i (baud_div_i),
        .rx_i       (rx_i),
        .rx_data_o  (rx_data),
        .rx_valid_o (rx_valid)
    );

    cmd_decoder u_dec (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .rx_data_i  (rx_data),
        .rx_valid_i (rx_valid),
        .cmd        (cmd_bus.issuer)
    );

    // Execute block holds commands while the transmitter is busy
    acc_execute u_exec (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .cmd         (cmd_bus.queue),
        .tx_busy_i   (tx_busy_o),
        .res_data_o  (res_data),
        .res_valid_o (res_valid)
    );

    uart_tx u_tx (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .baud_div_i  (baud_div_i),
        .res_data_i  (res_data),
        .res_valid_i (res_valid),
        .tx_o        (tx_o),
        .tx_busy_o   (tx_busy_o)
    );

endmodule

// File: test/uart_cmd_checker.sv
`timescale 1ns/1ps

module uart_cmd_checker (
    input logic                              clk_i,
    input logic                              rstn_i,
    input logic [uart_cmd_pkg::CREDIT_W-1:0] credit_cnt_i,
    input logic                              rx_valid_i,
    input logic                              op_pending_i,
    input logic                              cmd_valid_i,
    input logic [uart_cmd_pkg::CREDIT_W-1:0] q_count_i,
    input logic                              tx_line_i,
    input logic                              tx_busy_i
);
    import uart_cmd_pkg::*;

    credit_bound: assert property (@(posedge clk_i) disable iff (!rstn_i)
        credit_cnt_i <= CMD_CREDITS)
        else $error("Decoder credit count exceeds the queue depth");

    // Every operand byte must find a credit at equal rx and tx baud
    operand_has_credit: assert property (@(posedge clk_i) disable iff (!rstn_i)
        rx_valid_i && op_pending_i |-> credit_cnt_i != '0)
        else $error("Operand byte arrived while the decoder held no credit");

    no_push_when_full: assert property (@(posedge clk_i) disable iff (!rstn_i)
        cmd_valid_i |-> q_count_i != CMD_CREDITS)
        else $error("Command queue written while full");

    tx_idle_high: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !tx_busy_i |-> tx_line_i)
        else $error("tx line low while transmitter is idle");

endmodule

bind uart_cmd_top uart_cmd_checker chk0 (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .credit_cnt_i (u_dec.credit_cnt),
    .rx_valid_i   (rx_valid),
    .op_pending_i (u_dec.op_pending),
    .cmd_valid_i  (cmd_bus.cmd_valid),
    .q_count_i    (u_exec.q_count),
    .tx_line_i    (tx_o),
    .tx_busy_i    (tx_busy_o)
);

// File: test/uart_cmd_monitor.sv
`timescale 1ns/1ps

module uart_cmd_monitor (
    input logic        clk_i,
    input logic        rstn_i,
    input logic [15:0] baud_div_i,
    input logic        tx_i
);

    logic [7:0] exp_q [$];
    int         err_count = 0;
    int         rsp_count = 0;
    logic [9:0] frame;
    logic [7:0] exp_byte;

    always begin
        @(negedge tx_i);
        if (rstn_i) begin
            // Sample at mid-bit on falling clock edges, where tx is stable
            repeat (baud_div_i / 2) @(negedge clk_i);
            frame[0] = tx_i;
            for (int i = 1; i < 10; i++) begin
                repeat (baud_div_i) @(negedge clk_i);
                frame[i] = tx_i;
            end
            rsp_count++;
            if (frame[0] !== 1'b0) begin
                err_count++;
                $display("Start bit of response %0d did not stay low", rsp_count);
            end
            if (frame[9] !== 1'b1) begin
                err_count++;
                $display("Stop bit of response %0d is low", rsp_count);
            end
            if (exp_q.size() == 0) begin
                err_count++;
                $display("Response %0d (0x%h) arrived when none was expected",
                         rsp_count, frame[8:1]);
            end else begin
                exp_byte = exp_q.pop_front();
                if (frame[8:1] !== exp_byte) begin
                    err_count++;
                    $display("FAILED tx_data: expected 0x%h, got 0x%h", exp_byte, frame[8:1]);
                end
            end
        end
    end

endmodule

// File: test/uart_cmd_tb.sv
`timescale 1ns/1ps

module uart_cmd_tb;
    import uart_cmd_pkg::*;

    localparam int BAUD_DIV = 8;
    localparam int N_RANDOM = 50;
    // Two frames per command in every group, plus the two junk frames of the framing test
    localparam int FRAMES = 2 * (4 + N_RANDOM + 2 + 2) + 2;
    localparam int TIMEOUT_NS = FRAMES * 10 * BAUD_DIV * 4 * 2 + 20000;

    logic        clk_i;
    logic        rstn_i;
    logic [15:0] baud_div_i;
    logic        rx_i;
    logic        tx_o;
    logic        tx_busy_o;
    logic [7:0]  model_acc;
    logic [31:0] rnd;
    integer      seed;
    int          tb_errors = 0;

    uart_cmd_top dut0 (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .baud_div_i (baud_div_i),
        .rx_i       (rx_i),
        .tx_o       (tx_o),
        .tx_busy_o  (tx_busy_o)
    );

    uart_cmd_monitor mon0 (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .baud_div_i (baud_div_i),
        .tx_i       (tx_o)
    );

    always #2 clk_i = ~clk_i;

    // Returns the response byte and passes the new accumulator out through acc_out
    function automatic logic [7:0] model_command(input logic [7:0] acc_in,
            input logic [7:0] opb, input logic [7:0] operand, output logic [7:0] acc_out);
        logic [7:0] rsp;
        acc_out = acc_in;
        case (opb)
            OPB_LOAD: acc_out = operand;
            OPB_ADD:  acc_out = acc_in + operand;
            OPB_XOR:  acc_out = acc_in ^ operand;
            default:  acc_out = acc_in;
        endcase
        rsp = (opb inside {OPB_LOAD, OPB_ADD, OPB_XOR, OPB_READ}) ? acc_out : ERR_CODE;
        return rsp;
    endfunction

    task automatic send_frame(input logic [7:0] data, input logic stop_bit);
        rx_i = 1'b0;
        repeat (BAUD_DIV) @(negedge clk_i);
        for (int i = 0; i < 8; i++) begin
            rx_i = data[i];
            repeat (BAUD_DIV) @(negedge clk_i);
        end
        rx_i = stop_bit;
        repeat (BAUD_DIV) @(negedge clk_i);
        rx_i = 1'b1;
        if (!stop_bit) begin
            repeat (BAUD_DIV) @(negedge clk_i);
        end
    endtask

    task automatic send_command(input logic [7:0] opb, input logic [7:0] operand);
        logic [7:0] acc_new;
        mon0.exp_q.push_back(model_command(model_acc, opb, operand, acc_new));
        model_acc = acc_new;
        send_frame(opb, 1'b1);
        send_frame(operand, 1'b1);
    endtask

    task automatic check_idle(input int bits);
        repeat (bits * BAUD_DIV) begin
            @(negedge clk_i);
            if (tx_o !== 1'b1) begin
                tb_errors++;
                $display("FAILED tx_o: expected 0x1, got 0x%h", tx_o);
            end
            if (tx_busy_o !== 1'b0) begin
                tb_errors++;
                $display("FAILED tx_busy_o: expected 0x0, got 0x%h", tx_busy_o);
            end
        end
    endtask

    // The last stop bit is still on the line when the monitor takes its byte
    task automatic wait_for_responses(input int max_bits);
        int cycles;
        cycles = 0;
        while ((mon0.exp_q.size() != 0 || tx_busy_o !== 1'b0)
               && cycles < max_bits * BAUD_DIV) begin
            @(negedge clk_i);
            cycles++;
        end
        if (mon0.exp_q.size() != 0) begin
            tb_errors++;
            $display("%0d expected responses never arrived", mon0.exp_q.size());
        end
    endtask

    initial begin
        clk_i      = 1'b0;
        rstn_i     = 1'b0;
        baud_div_i = 16'(BAUD_DIV);
        rx_i       = 1'b1;
        model_acc  = 8'h00;
        seed       = 32'ha68c_cb2d;
        repeat (2) @(negedge clk_i);
        rstn_i = 1'b1;

        check_idle(20);

        // 0xF0 + 0x25 wraps past 255
        send_command(OPB_LOAD, 8'hF0);
        send_command(OPB_ADD, 8'h25);
        send_command(OPB_XOR, 8'h3C);
        send_command(OPB_READ, 8'h00);
        wait_for_responses(40);

        for (int n = 0; n < N_RANDOM; n++) begin
            rnd = $random(seed);
            case (rnd % 32'd5)
                0:       send_command(OPB_LOAD, rnd[23:16]);
                1:       send_command(OPB_ADD, rnd[23:16]);
                2:       send_command(OPB_XOR, rnd[23:16]);
                3:       send_command(OPB_READ, rnd[23:16]);
                default: send_command(8'hA0 | {3'b000, rnd[12:8]}, rnd[23:16]);
            endcase
        end
        wait_for_responses(40);

        send_command(8'h9C, 8'h11);
        send_command(OPB_READ, 8'h00);
        wait_for_responses(40);

        // Stray data byte and an opcode frame with a broken stop bit
        send_frame(8'h35, 1'b1);
        send_frame(OPB_LOAD, 1'b0);
        send_command(OPB_LOAD, 8'h5A);
        send_command(OPB_READ, 8'h00);
        wait_for_responses(40);
        check_idle(20);

        $display("Errors: %0d in responses, %0d in testbench checks (%0d responses seen)",
                 mon0.err_count, tb_errors, mon0.rsp_count);
        if (mon0.err_count == 0 && tb_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        tb_errors++;
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Errors: %0d in responses, %0d in testbench checks (%0d responses seen)",
                 mon0.err_count, tb_errors, mon0.rsp_count);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: list.f
verilog/uart_cmd_pkg.sv
verilog/cmd_if.sv
verilog/uart_rx.sv
verilog/cmd_decoder.sv
verilog/acc_execute.sv
verilog/uart_tx.sv
verilog/uart_cmd_top.sv
test/uart_cmd_checker.sv
test/uart_cmd_monitor.sv
test/uart_cmd_tb.sv

// File: Bender.yml
package:
  name: uart_cmd

sources:
  - verilog/uart_cmd_pkg.sv
  - verilog/cmd_if.sv
  - verilog/uart_rx.sv
  - verilog/cmd_decoder.sv
  - verilog/acc_execute.sv
  - verilog/uart_tx.sv
  - verilog/uart_cmd_top.sv
  - target: test
    files:
      - test/uart_cmd_checker.sv
      - test/uart_cmd_monitor.sv
      - test/uart_cmd_tb.sv
